// ==== rtl/spi_master.sv ====
`timescale 1ns/1ps

module spi_master
  import spi_master_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [CLK_DIV_W-1:0]   clk_div,
  input  logic                   clk_div_valid,
  input  word_t                  cmd,
  input  logic [LEN_FIELD_W-1:0] cmd_len,
  input  word_t                  addr,
  input  logic [LEN_FIELD_W-1:0] addr_len,
  input  bit_count_t             data_len,
  input  bit_count_t             dummy_rd,
  input  bit_count_t             dummy_wr,
  input  logic [CS_LINES-1:0]    csreg,
  input  logic                   rd,
  input  logic                   wr,
  input  logic                   qrd,
  input  logic                   qwr,
  input  word_t                  tx_data,
  input  logic                   tx_valid,
  input  logic                   rx_ready,
  input  logic                   sdi0,
  input  logic                   sdi1,
  input  logic                   sdi2,
  input  logic                   sdi3,
  output logic                   eot,
  output logic                   tx_ready,
  output word_t                  rx_data,
  output logic                   rx_valid,
  output logic                   spi_clk,
  output logic                   csn0,
  output logic                   csn1,
  output logic                   csn2,
  output logic                   csn3,
  output spi_mode_e              mode,
  output logic                   sdo0,
  output logic                   sdo1,
  output logic                   sdo2,
  output logic                   sdo3
);

  logic       clk_en;
  logic       spi_rise;
  logic       spi_fall;
  logic       quad;
  logic       tx_en;
  logic       rx_en;
  bit_count_t counter_tx;
  logic       counter_tx_upd;
  bit_count_t counter_rx;
  logic       counter_rx_upd;
  word_t      tx_word;
  logic       tx_data_valid;
  logic       tx_data_ready;
  logic       tx_done;
  logic       tx_clk_en;
  logic       rx_done;
  logic       rx_clk_en;

  spi_master_ctrl u_ctrl (
    .host_tx_data  (tx_data),
    .host_tx_valid (tx_valid),
    .host_tx_ready (tx_ready),
    .tx_data       (tx_word),
    .*
  );

  spi_master_clkgen u_clkgen (
    .en (clk_en),
    .*
  );

  spi_master_tx u_tx (
    .en             (tx_en),
    .tx_edge        (spi_fall),
    .counter_in     (counter_tx),
    .counter_in_upd (counter_tx_upd),
    .data           (tx_word),
    .data_valid     (tx_data_valid),
    .data_ready     (tx_data_ready),
    .clk_en         (tx_clk_en),
    .*
  );

  spi_master_rx u_rx (
    .en             (rx_en),
    .rx_edge        (spi_rise),
    .counter_in     (counter_rx),
    .counter_in_upd (counter_rx_upd),
    .data           (rx_data),
    .data_valid     (rx_valid),
    .data_ready     (rx_ready),
    .clk_en         (rx_clk_en),
    .*
  );

endmodule

// ==== rtl/spi_master_clkgen.sv ====
`timescale 1ns/1ps

module spi_master_clkgen
  import spi_master_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 en,
  input  logic [CLK_DIV_W-1:0] clk_div,
  input  logic                 clk_div_valid,
  output logic                 spi_clk,
  output logic                 spi_rise,
  output logic                 spi_fall
);

  logic [CLK_DIV_W-1:0] div_q;
  logic [CLK_DIV_W-1:0] count_q;
  logic                 running_q;
  logic                 active;
  logic                 tick;
  logic                 hit;

  // A high clock always finishes its half period, a low clock only rises when enabled
  assign active   = en | spi_clk;
  assign tick     = running_q & active;
  assign hit      = count_q == div_q;
  assign spi_rise = tick & hit & ~spi_clk;
  assign spi_fall = tick & hit & spi_clk;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      div_q     <= '0;
      count_q   <= '0;
      running_q <= 1'b0;
      spi_clk   <= 1'b0;
    end
    else
    begin
      running_q <= active;
      if (clk_div_valid)
      begin
        div_q   <= clk_div;
        count_q <= '0;
      end
      else if (!tick || hit)
        count_q <= '0;
      else
        count_q <= count_q + 1'b1;
      if (tick && hit)
        spi_clk <= ~spi_clk;
    end
  end

  a_half_period: assert property (@(posedge clk) disable iff (!rstn)
    (spi_rise || spi_fall) && div_q != '0 && !clk_div_valid |=> !(spi_rise || spi_fall));

endmodule

// ==== rtl/spi_master_ctrl.sv ====
`timescale 1ns/1ps

module spi_master_ctrl
  import spi_master_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   rd,
  input  logic                   wr,
  input  logic                   qrd,
  input  logic                   qwr,
  input  word_t                  cmd,
  input  logic [LEN_FIELD_W-1:0] cmd_len,
  input  word_t                  addr,
  input  logic [LEN_FIELD_W-1:0] addr_len,
  input  bit_count_t             data_len,
  input  bit_count_t             dummy_rd,
  input  bit_count_t             dummy_wr,
  input  logic [CS_LINES-1:0]    csreg,
  input  word_t                  host_tx_data,
  input  logic                   host_tx_valid,
  input  logic                   spi_fall,
  input  logic                   tx_done,
  input  logic                   tx_data_ready,
  input  logic                   tx_clk_en,
  input  logic                   rx_done,
  input  logic                   rx_clk_en,
  output logic                   eot,
  output logic                   host_tx_ready,
  output logic                   clk_en,
  output logic                   tx_en,
  output logic                   rx_en,
  output bit_count_t             counter_tx,
  output logic                   counter_tx_upd,
  output bit_count_t             counter_rx,
  output logic                   counter_rx_upd,
  output word_t                  tx_data,
  output logic                   tx_data_valid,
  output logic                   quad,
  output spi_mode_e              mode,
  output logic                   csn0,
  output logic                   csn1,
  output logic                   csn2,
  output logic                   csn3
);

  ctrl_state_e state_q;
  ctrl_state_e state_next;
  ctrl_state_e phase;
  ctrl_state_e after_dummy;
  ctrl_state_e after_addr;
  ctrl_state_e after_cmd;
  ctrl_state_e after_start;
  tx_src_e     tx_src;
  spi_mode_e   mode_next;
  logic        quad_q;
  logic        rd_q;
  logic        rd_dir;
  logic        start;
  logic        launch;
  logic        xfer;
  bit_count_t  dummy_len;
  bit_count_t  dummy_bits;
  word_t       cmd_aligned;
  word_t       addr_aligned;

  assign start  = (state_q == st_idle) & (rd | wr | qrd | qwr);
  assign quad   = (state_q == st_idle) ? (qrd | qwr) : quad_q;
  assign rd_dir = (state_q == st_idle) ? (rd | qrd) : rd_q;

  assign dummy_len  = rd_dir ? dummy_rd : dummy_wr;
  assign dummy_bits = quad ? (dummy_len << $clog2(QUAD_LANES)) : dummy_len;

  // Command and address come in right-aligned and leave from their top bit
  assign cmd_aligned  = cmd << (WORD_BITS - cmd_len);
  assign addr_aligned = addr << (WORD_BITS - addr_len);

  // Empty phases are skipped
  always_comb
  begin
    if (data_len == '0)
      after_dummy = st_idle;
    else if (rd_dir)
      after_dummy = st_data_rx;
    else
      after_dummy = st_data_tx;
    after_addr  = (dummy_len != '0) ? st_dummy : after_dummy;
    after_cmd   = (addr_len != '0) ? st_addr : after_addr;
    after_start = (cmd_len != '0) ? st_cmd : after_cmd;
  end

  always_comb
  begin
    state_next = state_q;
    launch     = 1'b0;
    eot        = 1'b0;
    case (state_q)
      st_idle:
      begin
        launch     = start;
        state_next = start ? after_start : st_idle;
      end
      st_cmd:
      begin
        launch     = tx_done;
        state_next = tx_done ? after_cmd : st_cmd;
      end
      st_addr:
      begin
        launch     = tx_done;
        state_next = tx_done ? after_addr : st_addr;
      end
      st_dummy:
      begin
        launch     = tx_done;
        state_next = tx_done ? after_dummy : st_dummy;
      end
      st_data_tx:
      begin
        launch     = tx_done;
        state_next = tx_done ? st_idle : st_data_tx;
      end
      st_data_rx:
        state_next = rx_done ? st_wait_edge : st_data_rx;
      st_wait_edge:
      begin
        // Let the last high phase of the serial clock finish
        eot        = spi_fall;
        state_next = spi_fall ? st_idle : st_wait_edge;
      end
      default:
        state_next = st_idle;
    endcase
    if (launch && state_next == st_idle)
      eot = 1'b1;
  end

  // A new phase is set up in the same cycle its predecessor ends
  assign phase = launch ? state_next : state_q;

  always_comb
  begin
    tx_src     = src_none;
    counter_tx = '0;
    mode_next  = spi_quad_rx;
    case (phase)
      st_cmd:
      begin
        tx_src     = src_cmd;
        counter_tx = bit_count_t'(cmd_len);
        mode_next  = quad ? spi_quad_tx : spi_std;
      end
      st_addr:
      begin
        tx_src     = src_addr;
        counter_tx = bit_count_t'(addr_len);
        mode_next  = quad ? spi_quad_tx : spi_std;
      end
      st_dummy:
      begin
        tx_src     = src_empty;
        counter_tx = dummy_bits;
        mode_next  = quad ? spi_quad_rx : spi_std;
      end
      st_data_tx:
      begin
        tx_src     = src_fifo;
        counter_tx = data_len;
        mode_next  = quad ? spi_quad_tx : spi_std;
      end
      st_data_rx, st_wait_edge:
        mode_next = quad ? spi_quad_rx : spi_std;
      default:
        mode_next = spi_quad_rx;
    endcase
  end

  assign tx_en          = tx_src != src_none;
  assign rx_en          = phase == st_data_rx;
  assign counter_tx_upd = launch & tx_en;
  assign counter_rx_upd = launch & rx_en;
  assign counter_rx     = data_len;

  always_comb
  begin
    tx_data       = '0;
    tx_data_valid = 1'b0;
    host_tx_ready = 1'b0;
    case (tx_src)
      src_empty:
        tx_data_valid = 1'b1;
      src_cmd:
      begin
        tx_data       = cmd_aligned;
        tx_data_valid = 1'b1;
      end
      src_addr:
      begin
        tx_data       = addr_aligned;
        tx_data_valid = 1'b1;
      end
      src_fifo:
      begin
        tx_data       = host_tx_data;
        tx_data_valid = host_tx_valid;
        host_tx_ready = tx_data_ready;
      end
      default:
        tx_data_valid = 1'b0;
    endcase
  end

  always_comb
  begin
    case (state_q)
      st_idle:      clk_en = start;
      st_data_tx:   clk_en = tx_clk_en;
      st_data_rx:   clk_en = rx_clk_en;
      st_wait_edge: clk_en = 1'b0;
      default:      clk_en = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q <= st_idle;
      quad_q  <= 1'b0;
      rd_q    <= 1'b0;
      mode    <= spi_quad_rx;
    end
    else
    begin
      state_q <= state_next;
      mode    <= mode_next;
      if (start)
      begin
        quad_q <= quad;
        rd_q   <= rd_dir;
      end
    end
  end

  assign xfer = start | (state_q != st_idle);
  assign csn0 = ~(csreg[0] & xfer);
  assign csn1 = ~(csreg[1] & xfer);
  assign csn2 = ~(csreg[2] & xfer);
  assign csn3 = ~(csreg[3] & xfer);

  a_eot_pulse: assert property (@(posedge clk) disable iff (!rstn) eot |=> !eot);

endmodule

// ==== rtl/spi_master_pkg.sv ====
package spi_master_pkg;

  localparam int unsigned WORD_BITS   = 32;
  localparam int unsigned QUAD_LANES  = 4;
  localparam int unsigned CS_LINES    = 4;
  localparam int unsigned LEN_FIELD_W = 6;
  localparam int unsigned CLK_DIV_W   = 8;

  // Counts serial edges inside one host word
  localparam int unsigned WORD_CNT_W  = $clog2(WORD_BITS);

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [15:0]          bit_count_t;

  typedef enum logic [1:0] {
    spi_std     = 2'b00,
    spi_quad_tx = 2'b01,
    spi_quad_rx = 2'b10
  } spi_mode_e;

  typedef enum logic [2:0] {
    st_idle,
    st_cmd,
    st_addr,
    st_dummy,
    st_data_tx,
    st_data_rx,
    st_wait_edge
  } ctrl_state_e;

  typedef enum logic [2:0] {
    src_none,
    src_empty,
    src_cmd,
    src_addr,
    src_fifo
  } tx_src_e;

endpackage

// ==== rtl/spi_master_rx.sv ====
`timescale 1ns/1ps

module spi_master_rx
  import spi_master_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       en,
  input  logic       rx_edge,
  input  logic       quad,
  input  bit_count_t counter_in,
  input  logic       counter_in_upd,
  input  logic       sdi0,
  input  logic       sdi1,
  input  logic       sdi2,
  input  logic       sdi3,
  input  logic       data_ready,
  output word_t      data,
  output logic       data_valid,
  output logic       rx_done,
  output logic       clk_en
);

  word_t                 shift_q;
  word_t                 shift_in;
  bit_count_t            bit_cnt_q;
  bit_count_t            target_q;
  logic [WORD_CNT_W-1:0] word_cnt_q;
  logic [WORD_CNT_W-1:0] word_last;
  logic                  active_q;
  logic                  sample;
  logic                  last_edge;
  logic                  word_end;
  logic                  word_out;

  assign word_last = quad ? WORD_CNT_W'(WORD_BITS / QUAD_LANES - 1) : WORD_CNT_W'(WORD_BITS - 1);
  assign sample    = en & active_q & rx_edge;
  assign last_edge = bit_cnt_q == target_q - 1'b1;
  assign word_end  = word_cnt_q == word_last;
  assign word_out  = sample & (word_end | last_edge);
  assign rx_done   = sample & last_edge;

  assign shift_in = quad ? {shift_q[WORD_BITS-QUAD_LANES-1:0], sdi3, sdi2, sdi1, sdi0}
                         : {shift_q[WORD_BITS-2:0], sdi0};

  // Hold the serial clock low until the host has taken the pending word
  assign clk_en = ~(data_valid & ~data_ready);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      active_q   <= 1'b0;
      bit_cnt_q  <= '0;
      target_q   <= '0;
      word_cnt_q <= '0;
      data_valid <= 1'b0;
    end
    else
    begin
      if (counter_in_upd)
      begin
        target_q   <= quad ? (counter_in >> $clog2(QUAD_LANES)) : counter_in;
        bit_cnt_q  <= '0;
        word_cnt_q <= '0;
        active_q   <= 1'b1;
      end
      else if (sample)
      begin
        bit_cnt_q  <= bit_cnt_q + 1'b1;
        word_cnt_q <= word_end ? '0 : word_cnt_q + 1'b1;
        if (last_edge)
          active_q <= 1'b0;
      end

      if (word_out)
        data_valid <= 1'b1;
      else if (data_ready)
        data_valid <= 1'b0;
    end
  end

  // The shifter restarts from zero so a short final word comes out right-aligned
  always_ff @(posedge clk)
  begin
    if (counter_in_upd)
      shift_q <= '0;
    else if (sample)
      shift_q <= word_out ? '0 : shift_in;
    if (word_out)
      data <= shift_in;
  end

  a_data_hold: assert property (@(posedge clk) disable iff (!rstn)
    data_valid && !data_ready |=> data_valid && $stable(data));

endmodule

// ==== rtl/spi_master_tx.sv ====
`timescale 1ns/1ps

module spi_master_tx
  import spi_master_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       en,
  input  logic       tx_edge,
  input  logic       quad,
  input  bit_count_t counter_in,
  input  logic       counter_in_upd,
  input  word_t      data,
  input  logic       data_valid,
  output logic       data_ready,
  output logic       tx_done,
  output logic       clk_en,
  output logic       sdo0,
  output logic       sdo1,
  output logic       sdo2,
  output logic       sdo3
);

  word_t                 shift_q;
  bit_count_t            bit_cnt_q;
  bit_count_t            target_q;
  logic [WORD_CNT_W-1:0] word_cnt_q;
  logic [WORD_CNT_W-1:0] word_last;
  logic                  active_q;
  logic                  shift_now;
  logic                  last_edge;
  logic                  word_end;
  logic                  need_word;
  logic                  load;

  assign word_last = quad ? WORD_CNT_W'(WORD_BITS / QUAD_LANES - 1) : WORD_CNT_W'(WORD_BITS - 1);
  assign shift_now = active_q & tx_edge;
  assign last_edge = bit_cnt_q == target_q - 1'b1;
  assign word_end  = word_cnt_q == word_last;

  // The next word is taken at the falling edge that retires the current one
  assign need_word  = ~active_q | (shift_now & (last_edge | word_end));
  assign data_ready = en & need_word;
  assign load       = data_ready & data_valid;
  assign tx_done    = shift_now & last_edge;
  assign clk_en     = ~(en & need_word & ~data_valid);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      active_q   <= 1'b0;
      bit_cnt_q  <= '0;
      target_q   <= '0;
      word_cnt_q <= '0;
    end
    else
    begin
      // Lengths arrive in bits, the counters run in serial edges
      if (counter_in_upd)
      begin
        target_q  <= quad ? (counter_in >> $clog2(QUAD_LANES)) : counter_in;
        bit_cnt_q <= '0;
      end
      else if (shift_now)
        bit_cnt_q <= bit_cnt_q + 1'b1;

      if (load)
      begin
        active_q   <= 1'b1;
        word_cnt_q <= '0;
      end
      else if (shift_now)
      begin
        word_cnt_q <= word_cnt_q + 1'b1;
        if (last_edge || word_end)
          active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
      shift_q <= data;
    else if (shift_now)
      shift_q <= quad ? (shift_q << QUAD_LANES) : (shift_q << 1);
  end

  assign sdo3 = quad & shift_q[WORD_BITS-1];
  assign sdo2 = quad & shift_q[WORD_BITS-2];
  assign sdo1 = quad & shift_q[WORD_BITS-3];
  assign sdo0 = quad ? shift_q[WORD_BITS-4] : shift_q[WORD_BITS-1];

  // A quad phase shorter than one edge would never finish
  a_len_nonzero: assert property (@(posedge clk) disable iff (!rstn)
    counter_in_upd |-> (quad ? (counter_in >> $clog2(QUAD_LANES)) : counter_in) != '0);

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds and runs the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_spi_master -f spi_master.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_spi_master
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// ==== spi_master.f ====
rtl/spi_master_pkg.sv
rtl/spi_master_clkgen.sv
rtl/spi_master_tx.sv
rtl/spi_master_rx.sv
rtl/spi_master_ctrl.sv
rtl/spi_master.sv
test/spi_device_model.sv
test/tb_spi_master.sv

// ==== test/spi_device_model.sv ====
`timescale 1ns/1ps

module spi_device_model
  import spi_master_pkg::*;
(
  input  logic      spi_clk,
  input  logic      csn0,
  input  logic      csn1,
  input  logic      csn2,
  input  logic      csn3,
  input  spi_mode_e mode,
  input  logic      sdo0,
  input  logic      sdo1,
  input  logic      sdo2,
  input  logic      sdo3,
  output logic      sdi0,
  output logic      sdi1,
  output logic      sdi2,
  output logic      sdi3
);

  // Bits seen on the sdo lines, oldest first
  logic        captured[$];
  // Read nibble for each rising edge of a transfer, sdi3 in the top bit
  logic [3:0]  script [0:255];
  int unsigned rise_cnt;
  logic        cs_idle;

  assign cs_idle = csn0 & csn1 & csn2 & csn3;

  initial
  begin
    rise_cnt = 0;
    {sdi3, sdi2, sdi1, sdi0} = 4'h0;
    for (int i = 0; i < 256; i++)
      script[i] = 4'h0;
  end

  // Lines are only sampled in the two modes where the master drives them
  always @(posedge spi_clk or posedge cs_idle)
  begin
    if (cs_idle)
      rise_cnt <= 0;
    else
    begin
      rise_cnt <= rise_cnt + 1;
      if (mode == spi_std)
        captured.push_back(sdo0);
      else if (mode == spi_quad_tx)
      begin
        captured.push_back(sdo3);
        captured.push_back(sdo2);
        captured.push_back(sdo1);
        captured.push_back(sdo0);
      end
    end
  end

  always @(negedge spi_clk or negedge cs_idle)
  begin
    if (!cs_idle)
      {sdi3, sdi2, sdi1, sdi0} <= script[rise_cnt % 256];
  end

endmodule

// ==== test/tb_spi_master.sv ====
`timescale 1ns/1ps

module tb_spi_master
  import spi_master_pkg::*;
();

  localparam int unsigned NUM_TRANS      = 40;
  localparam int unsigned TIMEOUT_CYCLES = NUM_TRANS * 400 * 8;

  logic                   clk = 1'b0;
  logic                   rstn;
  logic [CLK_DIV_W-1:0]   clk_div;
  logic                   clk_div_valid;
  word_t                  cmd;
  logic [LEN_FIELD_W-1:0] cmd_len;
  word_t                  addr;
  logic [LEN_FIELD_W-1:0] addr_len;
  bit_count_t             data_len;
  bit_count_t             dummy_rd;
  bit_count_t             dummy_wr;
  logic [CS_LINES-1:0]    csreg;
  logic                   rd;
  logic                   wr;
  logic                   qrd;
  logic                   qwr;
  word_t                  tx_data;
  logic                   tx_valid;
  logic                   rx_ready;
  logic                   sdi0;
  logic                   sdi1;
  logic                   sdi2;
  logic                   sdi3;
  logic                   eot;
  logic                   tx_ready;
  word_t                  rx_data;
  logic                   rx_valid;
  logic                   spi_clk;
  logic                   csn0;
  logic                   csn1;
  logic                   csn2;
  logic                   csn3;
  spi_mode_e              mode;
  logic                   sdo0;
  logic                   sdo1;
  logic                   sdo2;
  logic                   sdo3;

  word_t                  tx_words[$];
  word_t                  exp_rx[$];
  logic                   exp_bits[$];
  int unsigned            tx_idx;
  int unsigned            rx_idx;
  int unsigned            eot_cnt;
  int unsigned            cycles;
  int unsigned            last_rise;
  logic                   busy;
  logic                   have_rise;
  logic                   disturbed;
  logic                   stall_q;
  logic [CLK_DIV_W-1:0]   div_now;

  spi_master UUT (.*);

  spi_device_model dev (.*);

  initial
  begin
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_bits(input bit_count_t got, input bit_count_t exp, input string what);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_cs(input logic [CS_LINES-1:0] got, input logic [CS_LINES-1:0] exp,
                          input string what);
    if (got !== exp)
      report_failure($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  // Handshakes, eot pulses and the stall conditions are taken at the rising clock edge
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      report_failure("Timeout: the transactions did not finish within the cycle limit");
    if (eot)
      eot_cnt = eot_cnt + 1;
    if (tx_valid && tx_ready)
      tx_idx = tx_idx + 1;
    if (rx_valid && rx_ready)
    begin
      if (rx_idx >= exp_rx.size())
        report_failure("The master delivered more receive words than were requested");
      check_word(rx_data, exp_rx[rx_idx], "rx word");
      rx_idx = rx_idx + 1;
    end
    if (busy)
      check_cs({csn3, csn2, csn1, csn0}, ~csreg, "csn during transfer");
    if (eot)
      busy = 1'b0;
    stall_q = !spi_clk && ((tx_ready && !tx_valid) || (rx_valid && !rx_ready));
    if ((tx_ready && !tx_valid) || (rx_valid && !rx_ready))
      disturbed = 1'b1;
  end

  always @(negedge clk)
  begin
    if (stall_q && spi_clk)
      report_failure("The serial clock rose while a data port was stalled");
    tx_data  = (tx_idx < tx_words.size()) ? tx_words[tx_idx] : '0;
    tx_valid = ($urandom % 4 != 0) && (tx_idx < tx_words.size());
    rx_ready = ($urandom % 3 != 0) && rstn;
  end

  // Without back-pressure every period of the serial clock is exactly 2*(div+1) cycles
  always @(posedge spi_clk)
  begin
    if (have_rise && !disturbed)
      check_bits(bit_count_t'(cycles - last_rise), bit_count_t'(2 * (div_now + 1)),
                 "spi_clk rise period");
    last_rise = cycles;
    have_rise = 1'b1;
    disturbed = 1'b0;
  end

  task automatic run_transaction();
    logic        quad;
    logic        read;
    int          clen;
    int          alen;
    int          dlen;
    int          nwords;
    int          pre;
    int          edges;
    int          i;
    int          k;
    logic [3:0]  nib;
    word_t       acc;
    int unsigned exp_len;

    quad   = $urandom % 2;
    read   = $urandom % 2;
    clen   = quad ? 4 * ($urandom % 9) : $urandom % 33;
    alen   = quad ? 4 * ($urandom % 9) : $urandom % 33;
    nwords = 1 + $urandom % 3;
    @(negedge clk);
    cmd           = $urandom;
    addr          = $urandom;
    cmd_len       = clen[LEN_FIELD_W-1:0];
    addr_len      = alen[LEN_FIELD_W-1:0];
    dummy_rd      = bit_count_t'($urandom % 9);
    dummy_wr      = bit_count_t'($urandom % 9);
    data_len      = bit_count_t'(nwords * WORD_BITS);
    csreg         = CS_LINES'(1 + $urandom % 15);
    div_now       = CLK_DIV_W'($urandom % 4);
    clk_div       = div_now;
    clk_div_valid = 1'b1;
    dlen          = read ? dummy_rd : dummy_wr;

    // Reference stream, MSB first, in the order the device sees it
    exp_bits.delete();
    exp_rx.delete();
    tx_words.delete();
    tx_idx = 0;
    for (i = clen - 1; i >= 0; i--)
      exp_bits.push_back(cmd[i]);
    for (i = alen - 1; i >= 0; i--)
      exp_bits.push_back(addr[i]);
    if (!quad)
      for (i = 0; i < dlen; i++)
        exp_bits.push_back(1'b0);
    pre   = quad ? (clen + alen) / 4 + dlen : clen + alen + dlen;
    edges = quad ? nwords * 8 : nwords * 32;
    for (i = 0; i < 256; i++)
      dev.script[i] = 4'h0;
    if (read)
    begin
      acc = '0;
      for (k = 0; k < edges; k++)
      begin
        nib = quad ? 4'($urandom % 16) : 4'($urandom % 2);
        dev.script[pre + k] = nib;
        acc = quad ? {acc[WORD_BITS-5:0], nib} : {acc[WORD_BITS-2:0], nib[0]};
        if ((k + 1) % (quad ? 8 : 32) == 0)
          exp_rx.push_back(acc);
      end
    end
    else
      for (k = 0; k < nwords; k++)
      begin
        acc = $urandom;
        tx_words.push_back(acc);
        for (i = WORD_BITS - 1; i >= 0; i--)
          exp_bits.push_back(acc[i]);
      end
    exp_len = exp_bits.size() + ((read && !quad) ? nwords * 32 : 0);

    @(negedge clk);
    clk_div_valid = 1'b0;
    dev.captured.delete();
    eot_cnt   = 0;
    rx_idx    = 0;
    have_rise = 1'b0;
    rd        = read && !quad;
    qrd       = read && quad;
    wr        = !read && !quad;
    qwr       = !read && quad;
    busy      = 1'b1;
    @(negedge clk);
    {rd, wr, qrd, qwr} = 4'b0000;

    while (eot_cnt == 0 || rx_idx < exp_rx.size())
      @(negedge clk);
    check_cs({csn3, csn2, csn1, csn0}, 4'hf, "csn after eot");
    repeat (4) @(negedge clk);
    check_bits(bit_count_t'(eot_cnt), 16'd1, "eot pulses");
    check_bits(bit_count_t'(dev.captured.size()), bit_count_t'(exp_len), "captured length");
    for (i = 0; i < exp_bits.size(); i++)
      check_word(word_t'(dev.captured[i]), word_t'(exp_bits[i]), $sformatf("sdo bit %0d", i));
  endtask

  initial
  begin
    void'($urandom(32'h6972f68b));
    rstn          = 1'b0;
    clk_div       = '0;
    clk_div_valid = 1'b0;
    cmd           = '0;
    cmd_len       = '0;
    addr          = '0;
    addr_len      = '0;
    data_len      = '0;
    dummy_rd      = '0;
    dummy_wr      = '0;
    csreg         = '0;
    {rd, wr, qrd, qwr} = 4'b0000;
    tx_data   = '0;
    tx_valid  = 1'b0;
    rx_ready  = 1'b0;
    cycles    = 0;
    eot_cnt   = 0;
    tx_idx    = 0;
    rx_idx    = 0;
    busy      = 1'b0;
    have_rise = 1'b0;
    disturbed = 1'b0;
    stall_q   = 1'b0;
    div_now   = '0;
    repeat (10) @(negedge clk);
    rstn = 1'b1;
    repeat (2) @(negedge clk);
    for (int n = 0; n < NUM_TRANS; n++)
      run_transaction();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
